// ==== bus_timer.sv ====
`timescale 1ns/1ps

module bus_timer import cpu_pkg::*; (
    input  logic clock,
    input  logic rst_n,
    input  logic waiting,
    output logic timeout
);

    logic [TIMER_W-1:0] count;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            timeout <= 1'b0;
        end else if (!waiting) begin
            count   <= '0;
            timeout <= 1'b0;
        end else begin
            // saturate so the pulse fires once per request
            if (count != TIMER_W'(MEM_TIMEOUT)) count <= count + 1'b1;
            timeout <= (count == TIMER_W'(MEM_TIMEOUT - 1));
        end
    end

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    output logic     mem_req,
    output logic     mem_we,
    output addr_t    mem_addr,
    output data_t    mem_wdata,
    input  logic     mem_ack,
    input  data_t    mem_rdata,
    output logic     commit_valid,
    output logic     commit_wr_en,
    output reg_idx_t commit_wr_idx,
    output data_t    commit_wr_data,
    output addr_t    commit_pc,
    output data_t    completed_insts,
    output status_t  status
);

    // fetch side
    logic     inst_req, inst_req_run, inst_done;
    addr_t    inst_addr, fetch_pc;
    logic     fetch_valid;
    inst_t    fetch_inst;

    // if_id register
    logic     if_id_valid;
    inst_t    if_id_inst;
    addr_t    if_id_pc;

    // decode outputs
    opcode_t  dec_opcode;
    reg_idx_t dec_rd, dec_rs;
    data_t    dec_imm;
    logic     dec_writes_reg, dec_is_mem, dec_illegal;

    // id_ex register
    logic     ex_valid, ex_writes_reg, ex_is_mem, ex_illegal;
    opcode_t  ex_opcode;
    reg_idx_t ex_rd, ex_rs;
    data_t    ex_imm;
    addr_t    ex_pc;

    // exec and memory side
    logic     stall, squash, data_req, data_we, data_done, waiting, timeout;
    addr_t    redirect_pc, data_addr;
    data_t    data_wdata, rdata;

    ////////////////////////////////////////////////////////////
    // fetch and if_id
    ////////////////////////////////////////////////////////////

    fetch_stage fetch (
        .clock(clock), .rst_n(rst_n), .stall(stall), .squash(squash),
        .redirect_pc(redirect_pc), .inst_done(inst_done), .rdata(rdata),
        .inst_req(inst_req), .inst_addr(inst_addr), .fetch_valid(fetch_valid),
        .fetch_inst(fetch_inst), .fetch_pc(fetch_pc)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) if_id_valid <= 1'b0;
        else if (squash) if_id_valid <= 1'b0;
        else if (!stall) if_id_valid <= fetch_valid;
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            if_id_inst <= fetch_inst;
            if_id_pc   <= fetch_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // decode and id_ex
    ////////////////////////////////////////////////////////////

    decode_stage decode (
        .inst(if_id_inst), .valid(if_id_valid), .opcode(dec_opcode),
        .rd(dec_rd), .rs(dec_rs), .imm(dec_imm), .writes_reg(dec_writes_reg),
        .is_mem(dec_is_mem), .illegal(dec_illegal)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n || squash) begin
            ex_valid      <= 1'b0;
            ex_writes_reg <= 1'b0;
            ex_is_mem     <= 1'b0;
            ex_illegal    <= 1'b0;
        end else if (!stall) begin
            ex_valid      <= if_id_valid;
            ex_writes_reg <= dec_writes_reg;
            ex_is_mem     <= dec_is_mem;
            ex_illegal    <= dec_illegal;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            ex_opcode <= dec_opcode;
            ex_rd     <= dec_rd;
            ex_rs     <= dec_rs;
            ex_imm    <= dec_imm;
            ex_pc     <= if_id_pc;
        end
    end

    ////////////////////////////////////////////////////////////
    // execute, arbiter, bus timer
    ////////////////////////////////////////////////////////////

    exec_stage exec (
        .clock(clock), .rst_n(rst_n), .valid(ex_valid), .opcode(ex_opcode),
        .rd(ex_rd), .rs(ex_rs), .imm(ex_imm), .writes_reg(ex_writes_reg),
        .is_mem(ex_is_mem), .illegal(ex_illegal), .pc(ex_pc),
        .data_done(data_done), .rdata(rdata), .timeout(timeout),
        .stall(stall), .squash(squash), .redirect_pc(redirect_pc),
        .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .commit_valid(commit_valid),
        .commit_wr_en(commit_wr_en), .commit_wr_idx(commit_wr_idx),
        .commit_wr_data(commit_wr_data), .commit_pc(commit_pc),
        .completed_insts(completed_insts), .status(status)
    );

    // a fetch still pending after halt or fault never reaches the bus
    assign inst_req_run = inst_req && (status == STATUS_RUN);

    mem_arbiter arbiter (
        .clock(clock), .rst_n(rst_n), .inst_req(inst_req_run), .inst_addr(inst_addr),
        .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .timeout(timeout), .inst_done(inst_done), .data_done(data_done),
        .rdata(rdata), .waiting(waiting), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    bus_timer timer (
        .clock(clock), .rst_n(rst_n), .waiting(waiting), .timeout(timeout)
    );

endmodule

// ==== cpu_assert.sv ====
`timescale 1ns/1ps

module cpu_assert import cpu_pkg::*; (
    input logic    clock,
    input logic    rst_n,
    input logic    mem_req,
    input logic    mem_we,
    input addr_t   mem_addr,
    input data_t   mem_wdata,
    input logic    mem_ack,
    input logic    timeout,
    input status_t status
);

    // running total of assertion failures
    int failures = 0;

    // req stays up until ack, unless the bus timer gives up
    req_held: assert property (@(posedge clock) disable iff (!rst_n)
        mem_req && !mem_ack && !timeout |=> mem_req)
    else begin
        failures++;
        $error("mem_req dropped before mem_ack");
    end

    // request fields frozen while req is high
    req_stable: assert property (@(posedge clock) disable iff (!rst_n)
        mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
    else begin
        failures++;
        $error("memory request fields changed while mem_req was high");
    end

    // next request only after ack has fallen
    req_after_ack: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(mem_req) |-> !$past(mem_ack))
    else begin
        failures++;
        $error("mem_req rose while mem_ack was still high");
    end

    // halt, illegal and fault are sticky until reset
    status_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        status != STATUS_RUN |=> status == $past(status))
    else begin
        failures++;
        $error("status left a stopped state without reset");
    end

endmodule

bind cpu cpu_assert checks (
    .clock(clock), .rst_n(rst_n), .mem_req(mem_req), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ack(mem_ack),
    .timeout(timeout), .status(status)
);

// ==== cpu_pkg.sv ====
package cpu_pkg;

    // one machine word everywhere
    typedef logic [15:0] addr_t;
    typedef logic [15:0] data_t;
    typedef logic [15:0] inst_t;

    // instruction fields
    typedef logic [1:0] reg_idx_t;
    typedef logic [3:0] opcode_t;

    // processor status code
    typedef logic [1:0] status_t;

    // opcodes in inst[15:12]
    localparam opcode_t OP_LI   = 4'h1;
    localparam opcode_t OP_ADD  = 4'h2;
    localparam opcode_t OP_SUB  = 4'h3;
    localparam opcode_t OP_LD   = 4'h4;
    localparam opcode_t OP_ST   = 4'h5;
    localparam opcode_t OP_BEQZ = 4'h6;
    localparam opcode_t OP_HALT = 4'hf;

    // status codes
    localparam status_t STATUS_RUN       = 2'd0;
    localparam status_t STATUS_HALT      = 2'd1;
    localparam status_t STATUS_ILLEGAL   = 2'd2;
    localparam status_t STATUS_MEM_FAULT = 2'd3;

    // cycles without ack before the bus gives up
    localparam int MEM_TIMEOUT = 64;
    localparam int TIMER_W     = $clog2(MEM_TIMEOUT + 1);

    // first fetch address after reset
    localparam addr_t RESET_PC = 16'h0000;

endpackage

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  inst_t    inst,
    input  logic     valid,
    output opcode_t  opcode,
    output reg_idx_t rd,
    output reg_idx_t rs,
    output data_t    imm,
    output logic     writes_reg,
    output logic     is_mem,
    output logic     illegal
);

    logic known;
    logic wr;
    logic mem;

    // fixed field positions
    assign opcode = inst[15:12];
    assign rd     = inst[11:10];
    assign rs     = inst[9:8];

    always_comb begin
        known = 1'b1;
        wr    = 1'b0;
        mem   = 1'b0;
        // zero extension unless a branch offset
        imm   = {8'h00, inst[7:0]};
        case (opcode)
            OP_LI, OP_ADD, OP_SUB: wr = 1'b1;
            OP_LD: begin
                wr  = 1'b1;
                mem = 1'b1;
            end
            OP_ST: mem = 1'b1;
            OP_BEQZ: imm = {{8{inst[7]}}, inst[7:0]};
            OP_HALT: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    // bubbles carry no side effects
    assign writes_reg = valid && wr;
    assign is_mem     = valid && mem;
    assign illegal    = valid && !known;

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage import cpu_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     valid,
    input  opcode_t  opcode,
    input  reg_idx_t rd,
    input  reg_idx_t rs,
    input  data_t    imm,
    input  logic     writes_reg,
    input  logic     is_mem,
    input  logic     illegal,
    input  addr_t    pc,
    input  logic     data_done,
    input  data_t    rdata,
    input  logic     timeout,
    output logic     stall,
    output logic     squash,
    output addr_t    redirect_pc,
    output logic     data_req,
    output logic     data_we,
    output addr_t    data_addr,
    output data_t    data_wdata,
    output logic     commit_valid,
    output logic     commit_wr_en,
    output reg_idx_t commit_wr_idx,
    output data_t    commit_wr_data,
    output addr_t    commit_pc,
    output data_t    completed_insts,
    output status_t  status
);

    data_t regs [4];
    data_t rd_val;
    data_t rs_val;
    data_t result;
    logic  running;
    logic  active;
    logic  finish;
    logic  taken;

    ////////////////////////////////////////////////////////////
    // operands, alu, branch compare
    ////////////////////////////////////////////////////////////

    assign rd_val = regs[rd];
    assign rs_val = regs[rs];

    always_comb begin
        case (opcode)
            OP_LI:   result = imm;
            OP_ADD:  result = rd_val + rs_val;
            OP_SUB:  result = rd_val - rs_val;
            OP_LD:   result = rdata;
            default: result = '0;
        endcase
    end

    assign taken = (opcode == OP_BEQZ) && (rs_val == '0);

    ////////////////////////////////////////////////////////////
    // issue control
    ////////////////////////////////////////////////////////////

    assign running = (status == STATUS_RUN);
    // id_ex holds a wrong-path op during the squash cycle
    assign active  = valid && running && !squash;
    // alu ops finish at once, loads and stores wait for done
    assign finish  = active && !illegal && (!is_mem || data_done);

    // frozen forever once not running
    assign stall = !running || (active && is_mem && !data_done);

    // request level held until data_done
    assign data_req   = active && is_mem;
    assign data_we    = (opcode == OP_ST);
    assign data_addr  = rs_val;
    assign data_wdata = rd_val;

    ////////////////////////////////////////////////////////////
    // register file, status, retire count
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) regs[i] <= '0;
            status          <= STATUS_RUN;
            commit_valid    <= 1'b0;
            squash          <= 1'b0;
            completed_insts <= '0;
        end else begin
            commit_valid <= 1'b0;
            squash       <= 1'b0;
            // a timeout on either side kills the op in flight
            if (running && timeout) begin
                status <= STATUS_MEM_FAULT;
            end else if (active && illegal) begin
                status <= STATUS_ILLEGAL;
            end else if (finish) begin
                commit_valid    <= 1'b1;
                completed_insts <= completed_insts + 16'd1;
                if (writes_reg) regs[rd] <= result;
                if (opcode == OP_HALT) status <= STATUS_HALT;
                squash <= taken;
            end
        end
    end

    // commit record and branch target
    always_ff @(posedge clock) begin
        if (finish) begin
            commit_wr_en   <= writes_reg;
            commit_wr_idx  <= rd;
            commit_wr_data <= writes_reg ? result : '0;
            commit_pc      <= pc;
        end
        if (finish && taken) redirect_pc <= pc + 16'd1 + imm;
    end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  stall,
    input  logic  squash,
    input  addr_t redirect_pc,
    input  logic  inst_done,
    input  data_t rdata,
    output logic  inst_req,
    output addr_t inst_addr,
    output logic  fetch_valid,
    output inst_t fetch_inst,
    output addr_t fetch_pc
);

    addr_t pc;
    logic  busy;
    logic  discard;
    logic  hold_valid;
    inst_t hold_inst;
    logic  take;
    logic  start;

    // if_id grabs the held word this edge
    assign take  = hold_valid && !stall && !squash;
    // one word at a time, nothing new while stalled
    assign start = !busy && !hold_valid && !stall && !squash;

    assign inst_req    = busy;
    assign fetch_valid = hold_valid;
    assign fetch_inst  = hold_inst;
    // pc stays on the word in flight or held
    assign fetch_pc    = pc;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc         <= RESET_PC;
            busy       <= 1'b0;
            discard    <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (start) busy <= 1'b1;
            if (busy && inst_done) begin
                busy    <= 1'b0;
                discard <= 1'b0;
                // wrong-path word is dropped here
                if (!discard && !squash) hold_valid <= 1'b1;
            end
            if (squash) begin
                pc         <= redirect_pc;
                hold_valid <= 1'b0;
                // let the handshake finish, throw the word away
                if (busy && !inst_done) discard <= 1'b1;
            end else if (take) begin
                hold_valid <= 1'b0;
                pc         <= pc + 16'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) inst_addr <= pc;
        if (busy && inst_done) hold_inst <= rdata;
    end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  inst_req,
    input  addr_t inst_addr,
    input  logic  data_req,
    input  logic  data_we,
    input  addr_t data_addr,
    input  data_t data_wdata,
    input  logic  mem_ack,
    input  data_t mem_rdata,
    input  logic  timeout,
    output logic  inst_done,
    output logic  data_done,
    output data_t rdata,
    output logic  waiting,
    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output data_t mem_wdata
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_RELEASE
    } arb_state_e;

    arb_state_e state;
    logic       owner_data;
    logic       grant;
    logic       acked;

    // new request only once the previous ack has fallen
    assign grant = (state == ARB_IDLE) && !mem_ack && (data_req || inst_req);
    assign acked = (state == ARB_REQ) && mem_ack;

    // bus timer runs only while the memory owes us an ack
    assign waiting = (state == ARB_REQ) && !mem_ack;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ARB_IDLE;
            mem_req    <= 1'b0;
            owner_data <= 1'b0;
            inst_done  <= 1'b0;
            data_done  <= 1'b0;
        end else begin
            inst_done <= 1'b0;
            data_done <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (grant) begin
                        state      <= ARB_REQ;
                        mem_req    <= 1'b1;
                        // data side wins a tie
                        owner_data <= data_req;
                    end
                end
                ARB_REQ: begin
                    if (mem_ack) begin
                        state     <= ARB_RELEASE;
                        mem_req   <= 1'b0;
                        data_done <= owner_data;
                        inst_done <= !owner_data;
                    end else if (timeout) begin
                        // abandon silently, exec sees the timeout itself
                        state   <= ARB_IDLE;
                        mem_req <= 1'b0;
                    end
                end
                ARB_RELEASE: begin
                    // four-phase tail
                    if (!mem_ack) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // address and write data frozen for the whole request
    always_ff @(posedge clock) begin
        if (grant) begin
            mem_addr  <= data_req ? data_addr : inst_addr;
            mem_we    <= data_req && data_we;
            mem_wdata <= data_wdata;
        end
        if (acked) rdata <= mem_rdata;
    end

endmodule

// ==== sim.f ====
cpu_pkg.sv
mem_arbiter.sv
bus_timer.sv
fetch_stage.sv
decode_stage.sv
exec_stage.sv
cpu.sv
tb_mem_model.sv
cpu_assert.sv
tb_cpu.sv

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

    logic     clock;
    logic     rst_n;
    logic     mem_req, mem_we, mem_ack;
    addr_t    mem_addr;
    data_t    mem_wdata, mem_rdata;
    logic     commit_valid, commit_wr_en;
    reg_idx_t commit_wr_idx;
    data_t    commit_wr_data, completed_insts;
    addr_t    commit_pc;
    status_t  status;

    // program image and reference machine memory
    data_t    image [256];
    int       prog_len;
    integer   seed = 32'hc550;

    // expected commit stream and final state
    addr_t    exp_pc [$];
    logic     exp_we [$];
    reg_idx_t exp_idx [$];
    data_t    exp_data [$];
    data_t    exp_count;
    status_t  exp_status;
    int       exp_steps;

    logic     checking;
    int       cycles_left;

    cpu uut (
        .clock(clock), .rst_n(rst_n), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ack(mem_ack),
        .mem_rdata(mem_rdata), .commit_valid(commit_valid),
        .commit_wr_en(commit_wr_en), .commit_wr_idx(commit_wr_idx),
        .commit_wr_data(commit_wr_data), .commit_pc(commit_pc),
        .completed_insts(completed_insts), .status(status)
    );

    tb_mem_model mem (
        .clock(clock), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // program building and reference model
    ////////////////////////////////////////////////////////////

    function automatic inst_t encode(input opcode_t op, input int rd, input int rs,
                                     input int imm);
        return {op, 2'(rd), 2'(rs), 8'(imm)};
    endfunction

    task automatic emit(input inst_t word);
        image[prog_len] = word;
        prog_len++;
    endtask

    // fill word depends on the whole address
    task automatic new_program();
        for (int i = 0; i < 256; i++) image[i] = {8'(i) ^ 8'ha5, ~8'(i)};
        prog_len = 0;
    endtask

    function automatic void record(input addr_t pc, input logic we, input reg_idx_t idx,
                                   input data_t value);
        exp_pc.push_back(pc);
        exp_we.push_back(we);
        exp_idx.push_back(idx);
        exp_data.push_back(value);
        exp_count++;
    endfunction

    // walks the image in program order one instruction per step
    function automatic void interpret();
        data_t    r [4];
        addr_t    pc;
        inst_t    w;
        data_t    a;
        reg_idx_t rd;
        r          = '{default: '0};
        pc         = RESET_PC;
        exp_status = STATUS_RUN;
        exp_count  = '0;
        exp_steps  = 0;
        while (exp_status == STATUS_RUN && exp_steps < 500) begin
            w  = image[pc[7:0]];
            rd = w[11:10];
            a  = r[w[9:8]];
            exp_steps++;
            case (w[15:12])
                OP_LI: begin
                    r[rd] = {8'h00, w[7:0]};
                    record(pc, 1'b1, rd, r[rd]);
                end
                OP_ADD: begin
                    r[rd] = r[rd] + a;
                    record(pc, 1'b1, rd, r[rd]);
                end
                OP_SUB: begin
                    r[rd] = r[rd] - a;
                    record(pc, 1'b1, rd, r[rd]);
                end
                OP_LD: begin
                    if (a >= 16'hff00) begin
                        exp_status = STATUS_MEM_FAULT;
                    end else begin
                        r[rd] = image[a[7:0]];
                        record(pc, 1'b1, rd, r[rd]);
                    end
                end
                OP_ST: begin
                    if (a >= 16'hff00) begin
                        exp_status = STATUS_MEM_FAULT;
                    end else begin
                        image[a[7:0]] = r[rd];
                        record(pc, 1'b0, rd, '0);
                    end
                end
                OP_BEQZ: begin
                    record(pc, 1'b0, rd, '0);
                    // offset only as the common +1 follows below
                    if (a == '0) pc = pc + {{8{w[7]}}, w[7:0]};
                end
                OP_HALT: begin
                    record(pc, 1'b0, rd, '0);
                    exp_status = STATUS_HALT;
                end
                default: exp_status = STATUS_ILLEGAL;
            endcase
            pc = pc + 16'd1;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // one program from reset to stop
    ////////////////////////////////////////////////////////////

    task automatic run_program(input string name);
        @(negedge clock);
        rst_n = 1'b0;
        for (int i = 0; i < 256; i++) mem.words[i] = image[i];
        interpret();
        repeat (10) @(negedge clock);
        rst_n       = 1'b1;
        checking    = 1'b1;
        cycles_left = (exp_steps + 1) * (MEM_TIMEOUT + 20);
        while (status == STATUS_RUN) @(negedge clock);
        // drain so a late commit shows up in the compare process
        repeat (20) @(negedge clock);
        checking    = 1'b0;
        cycles_left = 0;
        if (exp_pc.size() != 0) begin
            abort_run($sformatf("%s: %0d expected commits never came", name, exp_pc.size()));
        end
        check({name, " completed_insts"}, completed_insts, exp_count);
        check({name, " status"}, 16'(status), 16'(exp_status));
        $display("%s: %0d commits", name, exp_count);
    endtask

    // commit stream against the reference queue
    initial begin
        addr_t    want_pc;
        logic     want_we;
        reg_idx_t want_idx;
        data_t    want_data;
        forever begin
            @(negedge clock);
            // bound checker fired on the memory port or status
            if (uut.checks.failures != 0) begin
                abort_run("a bound assertion on the memory port or status fired");
            end
            if (checking && commit_valid) begin
                if (exp_pc.size() == 0) begin
                    abort_run($sformatf("unexpected commit of pc %h", commit_pc));
                end else begin
                    want_pc   = exp_pc.pop_front();
                    want_we   = exp_we.pop_front();
                    want_idx  = exp_idx.pop_front();
                    want_data = exp_data.pop_front();
                    check("commit_pc", commit_pc, want_pc);
                    check("commit_wr_en", 16'(commit_wr_en), 16'(want_we));
                    // index and data only carry meaning on a write
                    if (want_we) begin
                        check("commit_wr_idx", 16'(commit_wr_idx), 16'(want_idx));
                        check("commit_wr_data", commit_wr_data, want_data);
                    end
                end
            end
        end
    end

    // budget per program set in run_program
    initial begin
        forever begin
            @(posedge clock);
            if (cycles_left > 0) begin
                cycles_left--;
                if (cycles_left == 0) begin
                    $display("watchdog expired, the processor did not stop in time");
                    $display("Test failed");
                    $fatal(1);
                end
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        checking    = 1'b0;
        cycles_left = 0;

        // alu chain with random immediates and operands
        new_program();
        for (int k = 0; k < 4; k++) emit(encode(OP_LI, k, 0, $random(seed)));
        for (int k = 0; k < 10; k++) begin
            emit(encode(($random(seed) & 1) ? OP_ADD : OP_SUB, $random(seed),
                        $random(seed), 0));
        end
        emit(encode(OP_HALT, 0, 0, 0));
        run_program("alu");

        // store then load from same and other addresses
        new_program();
        emit(encode(OP_LI, 0, 0, 8'h80));
        emit(encode(OP_LI, 1, 0, $random(seed)));
        emit(encode(OP_ST, 1, 0, 0));
        emit(encode(OP_LI, 2, 0, 8'h81));
        emit(encode(OP_LI, 3, 0, $random(seed)));
        emit(encode(OP_ST, 3, 2, 0));
        emit(encode(OP_LD, 1, 2, 0));
        emit(encode(OP_LD, 3, 0, 0));
        emit(encode(OP_ADD, 1, 3, 0));
        emit(encode(OP_LI, 2, 0, 8'hc5));
        // untouched fill word
        emit(encode(OP_LD, 0, 2, 0));
        emit(encode(OP_HALT, 0, 0, 0));
        run_program("load_store");

        // forward skip then a countdown loop
        new_program();
        emit(encode(OP_LI, 0, 0, 0));
        emit(encode(OP_BEQZ, 0, 0, 2));
        emit(encode(OP_LI, 3, 0, 8'h11));
        emit(encode(OP_LI, 3, 0, 8'h22));
        emit(encode(OP_LI, 1, 0, 3));
        emit(encode(OP_LI, 2, 0, 1));
        emit(encode(OP_SUB, 1, 2, 0));
        emit(encode(OP_BEQZ, 0, 1, 1));
        emit(encode(OP_BEQZ, 0, 0, -3));
        emit(encode(OP_HALT, 0, 0, 0));
        run_program("branch");

        // nothing after halt may commit
        new_program();
        emit(encode(OP_LI, 0, 0, 1));
        emit(encode(OP_LI, 1, 0, 2));
        emit(encode(OP_ADD, 0, 1, 0));
        emit(encode(OP_HALT, 0, 0, 0));
        emit(encode(OP_LI, 2, 0, 9));
        emit(encode(OP_LI, 3, 0, 9));
        run_program("halt");

        new_program();
        emit(encode(OP_LI, 0, 0, 3));
        emit(encode(OP_ADD, 0, 0, 0));
        emit(encode(4'h9, 1, 0, 0));
        emit(encode(OP_LI, 1, 0, 5));
        emit(encode(OP_HALT, 0, 0, 0));
        run_program("illegal");

        // r0 = 0xffff lands in the unmapped page
        new_program();
        emit(encode(OP_LI, 0, 0, 0));
        emit(encode(OP_LI, 1, 0, 1));
        emit(encode(OP_SUB, 0, 1, 0));
        emit(encode(OP_LD, 2, 0, 0));
        emit(encode(OP_LI, 3, 0, 1));
        emit(encode(OP_HALT, 0, 0, 0));
        run_program("mem_fault");

        if (uut.checks.failures == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d assertion failures", uut.checks.failures);
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model import cpu_pkg::*; (
    input  logic  clock,
    input  logic  mem_req,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  data_t mem_wdata,
    output logic  mem_ack,
    output data_t mem_rdata
);

    // 256 words, aliased on the low address byte
    data_t  words [256];
    integer seed = 32'hc550;
    int     delay;

    // acts on the falling edge only, the cpu samples on the rising one
    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clock);
            // top page is unmapped, left hanging for the bus timer
            if (mem_req && mem_addr < 16'hff00) begin
                delay = 1 + ($unsigned($random(seed)) % 8);
                repeat (delay - 1) @(negedge clock);
                if (mem_we) begin
                    words[mem_addr[7:0]] = mem_wdata;
                end else begin
                    mem_rdata = words[mem_addr[7:0]];
                end
                mem_ack = 1'b1;
                // four-phase tail
                while (mem_req) @(negedge clock);
                mem_ack = 1'b0;
            end
        end
    end

endmodule
